//--- cpu_tests.txt
// word 0 program length, word 1 store count, then the program words,
// then one store record per line: word address, lane-aligned data, wmask
0000002b 00000011
10000093 ffb00113 00300193 12345237 00001297 40310333 403153b3 00315433
003124b3 00313533 0040a023 0050a223 0060a423 0070a623 0080a823 0090aa23
00a0ac23 022080a3 02409323 00808583 0090c603 00209683 00a0d703 0040a783
02b0a423 02c0a623 02d0a823 02e0aa23 02f0ac23 00310463 0230ae23 00314463
0420a023 00316463 0080086f 0420a223 00000013 0500a423 0a5008e7 0420a623
0420a823 0510aa23 0000006f
00000100 12345000 0000000f
00000104 00001010 0000000f
00000108 fffffff8 0000000f
0000010c ffffffff 0000000f
00000110 1fffffff 0000000f
00000114 00000001 0000000f
00000118 00000000 0000000f
00000120 fffffb00 00000002
00000124 50000000 0000000c
00000128 fffffff8 0000000f
0000012c 000000ff 0000000f
00000130 00001234 0000000f
00000134 0000ffff 0000000f
00000138 00001010 0000000f
0000013c 00000003 0000000f
00000148 0000008c 0000000f
00000154 0000009c 0000000f

//--- list.f
+incdir+.
rv32i_pkg.sv
dmem_if.sv
i_fetch.sv
i_decode.sv
execute.sv
mem_access.sv
write_back.sv
cpu.sv
cpu_chk.sv
cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_cpu -o sim_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- cpu_tb.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #5 rst = 1'b0;
    end
endmodule

module tb_monitor (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        imem_read,
    input wire logic        dmem_write,
    input wire logic        dmem_resp,
    input wire logic [31:0] dmem_address,
    input wire logic [31:0] dmem_wdata,
    input wire logic [3:0]  dmem_wmask,
    input wire logic [31:0] tests [256],
    output int              stores_seen,
    output int              check_errors
);
    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        stores_seen  = 0;
        check_errors = 0;
    end

    function automatic logic [31:0] lane_bits(input logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    task automatic compare_store(input int k);
        int          base;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        logic [3:0]  exp_mask;
        base     = 2 + int'(tests[0]) + 3 * k;
        exp_addr = tests[base];
        exp_data = tests[base + 1];
        exp_mask = tests[base + 2][3:0];
        if (dmem_address !== exp_addr) begin
            $display("CHECK FAILED store %0d dmem_address got %h expected %h",
                     k, dmem_address, exp_addr);
            check_errors++;
        end
        if (dmem_wmask !== exp_mask) begin
            $display("CHECK FAILED store %0d dmem_wmask got %h expected %h",
                     k, dmem_wmask, exp_mask);
            check_errors++;
        end
        // only the enabled lanes carry data
        if ((dmem_wdata & lane_bits(exp_mask)) !== (exp_data & lane_bits(exp_mask))) begin
            $display("CHECK FAILED store %0d dmem_wdata got %h expected %h",
                     k, dmem_wdata, exp_data);
            check_errors++;
        end
    endtask

    // resp is driven off the rising edge, so the falling edge sees it settled
    always @(negedge clk) begin
        // instruction port reads in every cycle out of reset
        if (!rst && imem_read !== 1'b1) begin
            $display("CHECK FAILED imem_read got %h expected %h", imem_read, 1'b1);
            check_errors++;
        end
        if (!rst && dmem_write && dmem_resp) begin
            if (stores_seen >= int'(tests[1])) begin
                $display("unexpected extra store to address %h", dmem_address);
                check_errors++;
            end else begin
                compare_store(stores_seen);
            end
            stores_seen++;
        end
    end
endmodule

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ns;

    logic        clk;
    logic        rst;
    logic [31:0] imem_address;
    logic        imem_read;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic [31:0] dmem_address;
    logic        dmem_read;
    logic        dmem_write;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;
    logic [31:0] tests [256];
    logic [31:0] mem [256];
    logic        loaded;
    logic        pending;
    int          delay;
    int          seed;
    int          stores_seen;
    int          check_errors;
    int          timeouts;

    tb_clock_gen clock_gen (.clk, .rst);

    cpu dut0 (.clk, .rst, .imem_address, .imem_read, .imem_rdata, .imem_resp,
              .dmem_address, .dmem_read, .dmem_write, .dmem_wmask, .dmem_wdata,
              .dmem_rdata, .dmem_resp);

    tb_monitor monitor (.clk, .rst, .imem_read, .dmem_write, .dmem_resp, .dmem_address,
                        .dmem_wdata, .dmem_wmask, .tests, .stores_seen, .check_errors);

    // instruction and data share one word array
    assign imem_rdata = mem[imem_address[9:2]];

    initial begin
        imem_resp  = 1'b0;
        dmem_rdata = '0;
        dmem_resp  = 1'b0;
        pending    = 1'b0;
        delay      = 0;
        seed       = 32'h30bf;
        timeouts   = 0;
        loaded     = 1'b0;
        $readmemh("cpu_tests.txt", tests);
        // untouched words carry their own address
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hdead0000 ^ (i * 4);
        end
        for (int i = 0; i < int'(tests[0]); i++) begin
            mem[i] = tests[2 + i];
        end
        loaded = 1'b1;
    end

    task automatic serve_access();
        int a;
        a = int'(dmem_address[9:2]);
        if (dmem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) mem[a][8*b +: 8] = dmem_wdata[8*b +: 8];
            end
        end else begin
            dmem_rdata = mem[a];
        end
        dmem_resp = 1'b1;
    endtask

    // data port with 0 to 3 wait cycles per access
    always @(posedge clk) begin
        #2;
        if (rst || dmem_resp) begin
            dmem_resp = 1'b0;
            pending   = 1'b0;
        end else if (dmem_read || dmem_write) begin
            if (!pending) begin
                pending = 1'b1;
                delay   = int'($unsigned($random(seed)) % 4);
            end
            if (delay == 0) begin
                serve_access();
                pending = 1'b0;
            end else begin
                delay--;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (int'(tests[0]) * 20) @(posedge clk);
        timeouts = 1;
        $display("timeout with %0d of %0d stores seen", stores_seen, tests[1]);
        $display("check errors %0d, timeouts %0d", check_errors, timeouts);
        $display("Something failed");
        $finish;
    end

    // a few idle cycles after the last store catch any extra ones
    initial begin
        wait (loaded);
        wait (stores_seen >= int'(tests[1]));
        repeat (20) @(posedge clk);
        $display("check errors %0d, timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- cpu_chk.sv
`default_nettype none

module cpu_chk (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        dmem_read,
    input wire logic        dmem_write,
    input wire logic [31:0] dmem_address,
    input wire logic [31:0] dmem_wdata,
    input wire logic [3:0]  dmem_wmask,
    input wire logic        dmem_resp
);
    timeunit 1ns;
    timeprecision 1ns;

    // one kind of access at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(dmem_read && dmem_write))
        else $error("data read and write requested together");

    // request held with the same address and data until resp
    request_stable: assert property (@(posedge clk) disable iff (rst)
        (dmem_read || dmem_write) && !dmem_resp |=>
            $stable({dmem_read, dmem_write, dmem_address, dmem_wdata, dmem_wmask}))
        else $error("data request changed before its response");

    // stage registers hold NOPs right out of reset
    idle_after_reset: assert property (@(posedge clk) $fell(rst) |->
        !dmem_read && !dmem_write)
        else $error("data request active in the cycle after reset");
endmodule

bind cpu cpu_chk chk0 (.clk, .rst, .dmem_read, .dmem_write, .dmem_address,
                       .dmem_wdata, .dmem_wmask, .dmem_resp);

`default_nettype wire

//--- cpu.sv
`default_nettype none
`include "rv32i_defines.svh"

module cpu import rv32i_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output rv32i_word   imem_address,
    output logic        imem_read,
    input  rv32i_word   imem_rdata,
    input  logic        imem_resp,
    output rv32i_word   dmem_address,
    output logic        dmem_read,
    output logic        dmem_write,
    output logic [3:0]  dmem_wmask,
    output rv32i_word   dmem_wdata,
    input  rv32i_word   dmem_rdata,
    input  logic        dmem_resp
);
    if_id_t    if_id;
    id_ex_t    id_ex, id_ex_next;
    ex_mem_t   ex_mem, ex_mem_next;
    mem_wb_t   mem_wb, mem_wb_next;
    rv32i_word fetch_pc;
    logic      stall;
    logic      branch_taken;
    rv32i_word target;
    rv32i_word regfile_in;
    logic [4:0] wb_rd;
    logic      load_regfile;

    dmem_if dbus ();

    // top-level pins onto the data interface
    assign dmem_address = dbus.address;
    assign dmem_read    = dbus.read;
    assign dmem_write   = dbus.write;
    assign dmem_wmask   = dbus.wmask;
    assign dmem_wdata   = dbus.wdata;
    assign dbus.rdata   = dmem_rdata;
    assign dbus.resp    = dmem_resp;

    // outstanding data access freezes everything
    assign stall = (dbus.read || dbus.write) && !dbus.resp;

    i_fetch i_fetch (.clk, .rst, .stall, .branch_taken, .target, .pc(fetch_pc),
                     .imem_address, .imem_read);
    i_decode i_decode (.clk, .rst, .id_in(if_id), .regfile_in, .rd(wb_rd),
                       .load_regfile, .id_out(id_ex_next));
    execute execute (.ex_in(id_ex), .ex_out(ex_mem_next), .branch_taken, .target);
    mem_access mem_access (.clk, .rst, .mem_in(ex_mem), .dbus(dbus.requester),
                           .mem_out(mem_wb_next));
    write_back write_back (.wb_in(mem_wb), .regfile_in, .rd(wb_rd), .load_regfile);

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id  <= '{pc: `RV32_RESET_PC, ir: `RV32_NOP};
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (!stall) begin
            // taken branch in execute kills the two younger slots
            if (branch_taken) begin
                if_id <= '{pc: fetch_pc, ir: `RV32_NOP};
                id_ex <= '0;
            end else begin
                if_id <= '{pc: fetch_pc, ir: imem_rdata};
                id_ex <= id_ex_next;
            end
            ex_mem <= ex_mem_next;
            mem_wb <= mem_wb_next;
        end
    end
endmodule

`default_nettype wire

//--- write_back.sv
`default_nettype none

module write_back import rv32i_pkg::*; (
    input  mem_wb_t    wb_in,
    output rv32i_word  regfile_in,
    output logic [4:0] rd,
    output logic       load_regfile
);
    rv32i_word lword;
    rv32i_word load_val;

    // addressed byte moved down to bit 0
    assign lword = wb_in.rdata >> {wb_in.alu_out[1:0], 3'b000};

    always_comb begin
        case (wb_in.ctrl.funct3)
            3'b000:  load_val = {{24{lword[7]}}, lword[7:0]};
            3'b001:  load_val = {{16{lword[15]}}, lword[15:0]};
            3'b100:  load_val = {24'b0, lword[7:0]};
            3'b101:  load_val = {16'b0, lword[15:0]};
            default: load_val = wb_in.rdata;
        endcase
    end

    always_comb begin
        case (wb_in.ctrl.wb_sel)
            wb_load: regfile_in = load_val;
            wb_uimm: regfile_in = wb_in.u_imm;
            wb_pc4:  regfile_in = wb_in.pc + 32'd4;
            default: regfile_in = wb_in.alu_out;
        endcase
    end

    assign rd = wb_in.rd;
    // no write for x0
    assign load_regfile = wb_in.ctrl.reg_write && (wb_in.rd != 5'd0);
endmodule

`default_nettype wire

//--- mem_access.sv
`default_nettype none

module mem_access import rv32i_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ex_mem_t  mem_in,
    dmem_if.requester dbus,
    output mem_wb_t  mem_out
);
    logic [1:0] off;
    logic [1:0] lane;
    rv32i_word  mdr;

    // halves sit on lane 0 or 2, words on lane 0
    assign off = mem_in.alu_out[1:0];
    always_comb begin
        case (mem_in.ctrl.funct3[1:0])
            2'b00:   lane = off;
            2'b01:   lane = {off[1], 1'b0};
            default: lane = 2'b00;
        endcase
    end

    always_comb begin
        case (mem_in.ctrl.funct3[1:0])
            2'b00:   dbus.wmask = 4'b0001 << lane;
            2'b01:   dbus.wmask = 4'b0011 << lane;
            default: dbus.wmask = 4'b1111;
        endcase
    end

    // word-aligned address, data shifted onto its lane
    assign dbus.address = {mem_in.alu_out[31:2], 2'b00};
    assign dbus.wdata   = mem_in.store_data << {lane, 3'b000};
    assign dbus.read    = mem_in.ctrl.mem_read;
    assign dbus.write   = mem_in.ctrl.mem_write;

    // last returned word
    always_ff @(posedge clk) begin
        if (rst) mdr <= '0;
        else if (dbus.resp) mdr <= dbus.rdata;
    end

    assign mem_out = '{pc: mem_in.pc, ctrl: mem_in.ctrl, alu_out: mem_in.alu_out,
                       rdata: dbus.resp ? dbus.rdata : mdr,
                       u_imm: mem_in.u_imm, rd: mem_in.rd};
endmodule

`default_nettype wire

//--- execute.sv
`default_nettype none

module execute import rv32i_pkg::*; (
    input  id_ex_t    ex_in,
    output ex_mem_t   ex_out,
    output logic      branch_taken,
    output rv32i_word target
);
    rv32i_word op_a;
    rv32i_word op_b;
    rv32i_word alu_out;
    logic [4:0] shamt;
    logic      cmp;
    logic      is_jal;
    logic      is_jalr;
    logic      is_br;

    // pc feeds auipc, immediate feeds all but reg-reg and branches
    assign op_a  = ex_in.ctrl.use_pc ? ex_in.pc : ex_in.rs1_val;
    assign op_b  = ex_in.ctrl.use_imm ? ex_in.imm : ex_in.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_in.ctrl.alu_op)
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $signed(op_a) >>> shamt;
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // branch compare on register values
    always_comb begin
        case (ex_in.ctrl.funct3)
            3'b000:  cmp = ex_in.rs1_val == ex_in.rs2_val;
            3'b001:  cmp = ex_in.rs1_val != ex_in.rs2_val;
            3'b100:  cmp = $signed(ex_in.rs1_val) < $signed(ex_in.rs2_val);
            3'b101:  cmp = $signed(ex_in.rs1_val) >= $signed(ex_in.rs2_val);
            3'b110:  cmp = ex_in.rs1_val < ex_in.rs2_val;
            3'b111:  cmp = ex_in.rs1_val >= ex_in.rs2_val;
            default: cmp = 1'b0;
        endcase
    end

    assign is_jal  = ex_in.ctrl.opcode == op_jal;
    assign is_jalr = ex_in.ctrl.opcode == op_jalr;
    assign is_br   = ex_in.ctrl.opcode == op_br;

    assign branch_taken = is_jal || is_jalr || (is_br && cmp);

    // jalr clears bit 0 of rs1 + imm
    assign target = is_jalr ? ((ex_in.rs1_val + ex_in.imm) & ~32'd1)
                            : ex_in.pc + ex_in.imm;

    assign ex_out = '{pc: ex_in.pc, ctrl: ex_in.ctrl, alu_out: alu_out,
                      store_data: ex_in.rs2_val, u_imm: ex_in.imm, rd: ex_in.rd};
endmodule

`default_nettype wire

//--- i_decode.sv
`default_nettype none

module i_decode import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  if_id_t     id_in,
    input  rv32i_word  regfile_in,
    input  logic [4:0] rd,
    input  logic       load_regfile,
    output id_ex_t     id_out
);
    rv32i_word  regs [32];
    rv32i_word  ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7b5;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rv32i_word  i_imm;
    rv32i_word  s_imm;
    rv32i_word  b_imm;
    rv32i_word  u_imm;
    rv32i_word  j_imm;
    ctrl_t      ctrl;
    rv32i_word  imm;
    alu_op_t    f3_op;

    assign ir     = id_in.ir;
    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign f7b5   = ir[30];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    // immediates for every format
    assign i_imm = {{20{ir[31]}}, ir[31:20]};
    assign s_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign b_imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm = {ir[31:12], 12'b0};
    assign j_imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // funct3 to alu op, funct7 bit picks sub and sra
    always_comb begin
        case (funct3)
            3'b000:  f3_op = (opcode == op_reg && f7b5) ? alu_sub : alu_add;
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b011:  f3_op = alu_sltu;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = f7b5 ? alu_sra : alu_srl;
            3'b110:  f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = opcode_t'(opcode);
        ctrl.funct3 = funct3;
        ctrl.alu_op = alu_add;
        ctrl.wb_sel = wb_alu;
        imm         = i_imm;
        case (opcode)
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_uimm;
                imm            = u_imm;
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_pc    = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = u_imm;
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                imm            = j_imm;
            end
            op_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
            end
            // comparator reads funct3 directly
            op_br: imm = b_imm;
            op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.wb_sel    = wb_load;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = s_imm;
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = f3_op;
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = f3_op;
            end
            // unknown opcodes keep the cleared control word
            default: ;
        endcase
    end

    // register file, x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load_regfile && rd != 5'd0) begin
            regs[rd] <= regfile_in;
        end
    end

    // write-through so a same-cycle write is seen by decode
    function automatic rv32i_word read_reg(input logic [4:0] sel);
        if (sel == 5'd0) return '0;
        if (load_regfile && rd == sel) return regfile_in;
        return regs[sel];
    endfunction

    assign id_out = '{pc: id_in.pc, ctrl: ctrl, rs1_val: read_reg(rs1),
                      rs2_val: read_reg(rs2), imm: imm, rd: ir[11:7]};
endmodule

`default_nettype wire

//--- i_fetch.sv
`default_nettype none
`include "rv32i_defines.svh"

module i_fetch import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      branch_taken,
    input  rv32i_word target,
    output rv32i_word pc,
    output rv32i_word imem_address,
    output logic      imem_read
);
    rv32i_word pc_next;

    // redirect from execute wins over sequential fetch
    assign pc_next = branch_taken ? target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV32_RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // instruction port is combinational, always reading
    assign imem_address = pc;
    assign imem_read    = 1'b1;
endmodule

`default_nettype wire

//--- dmem_if.sv
`default_nettype none

interface dmem_if import rv32i_pkg::*; ();
    // request, held until resp
    rv32i_word  address;
    logic       read;
    logic       write;
    logic [3:0] wmask;
    rv32i_word  wdata;
    // response, rdata valid with resp
    rv32i_word  rdata;
    logic       resp;

    modport requester (output address, read, write, wmask, wdata,
                       input rdata, resp);

    modport port (input address, read, write, wmask, wdata,
                  output rdata, resp);
endinterface

`default_nettype wire

//--- rv32i_pkg.sv
`default_nettype none
`include "rv32i_defines.svh"

package rv32i_pkg;

    typedef logic [`RV32_XLEN-1:0] rv32i_word;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // source of the register file write value
    typedef enum logic [1:0] {
        wb_alu, wb_load, wb_uimm, wb_pc4
    } wb_sel_t;

    typedef struct packed {
        opcode_t    opcode;
        alu_op_t    alu_op;
        logic [2:0] funct3;
        logic       use_imm;
        logic       use_pc;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        wb_sel_t    wb_sel;
    } ctrl_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word ir;
    } if_id_t;

    typedef struct packed {
        rv32i_word  pc;
        ctrl_t      ctrl;
        rv32i_word  rs1_val;
        rv32i_word  rs2_val;
        rv32i_word  imm;
        logic [4:0] rd;
    } id_ex_t;

    typedef struct packed {
        rv32i_word  pc;
        ctrl_t      ctrl;
        rv32i_word  alu_out;
        rv32i_word  store_data;
        rv32i_word  u_imm;
        logic [4:0] rd;
    } ex_mem_t;

    typedef struct packed {
        rv32i_word  pc;
        ctrl_t      ctrl;
        rv32i_word  alu_out;
        rv32i_word  rdata;
        rv32i_word  u_imm;
        logic [4:0] rd;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- rv32i_defines.svh
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// datapath width
`define RV32_XLEN 32

// first fetch address out of reset
`define RV32_RESET_PC 32'h0000_0000

// addi x0, x0, 0
// fills IF/ID on reset and on a flush
`define RV32_NOP 32'h0000_0013

`endif
